/* common/mem_stage_params.svh */
`ifndef MEM_STAGE_PARAMS_SVH
`define MEM_STAGE_PARAMS_SVH

`define WORD_SIZE 32

// Data RAM depth in words
`define RAM_WORDS 256

// Maintenance engine busy times, in cycles
`define IFLUSH_CYCLES 3
`define DFLUSH_CYCLES 5
`define ITLB_CYCLES 2
`define DTLB_CYCLES 4

`endif

/* common/mem_stage_pkg.sv */
`include "mem_stage_params.svh"

package mem_stage_pkg;

    typedef logic [`WORD_SIZE-1:0] word_t;

    // Store kinds reuse LB, LH and LW
    typedef enum logic [2:0] {
        LB   = 3'd0,
        LH   = 3'd1,
        LW   = 3'd2,
        LBU  = 3'd3,
        LHU  = 3'd4,
        NONE = 3'd5
    } load_type_t;

    typedef enum logic [2:0] {
        W_SEL_FROM_DLOAD = 3'd0,
        W_SEL_FROM_PC    = 3'd1,
        W_SEL_FROM_IMM_U = 3'd2,
        W_SEL_FROM_ALU   = 3'd3
    } w_sel_t;

    typedef struct packed {
        logic       dren;
        logic       dwen;
        load_type_t load_type;
        w_sel_t     w_sel;
        word_t      port_out;
        word_t      rs2_data;
        word_t      pc4;
        word_t      imm_U;
        logic [4:0] rd_m;
        logic       reg_write;
        logic       ifence;
        logic       sfence;
        logic       halt;
    } ex_mem_reg_t;

    typedef struct packed {
        logic       ren;
        logic       wen;
        word_t      addr;
        logic [3:0] byte_en;
        word_t      wdata;
    } dbus_req_t;

    typedef struct packed {
        word_t rdata;
        logic  busy;
        logic  error;
    } dbus_rsp_t;

    typedef struct packed {
        logic mal_l;
        logic mal_s;
        logic fault_l;
        logic fault_s;
    } mem_exc_t;

endpackage

/* mem_stage/dmem_extender.sv */
`timescale 1ns/10ps

module dmem_extender
    import mem_stage_pkg::*;
(
    input  word_t      dmem_in,
    input  load_type_t load_type,
    input  logic [3:0] byte_en,
    output word_t      ext_out
);
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    // Enabled byte lane
    always_comb begin
        case (byte_en)
            4'b0010: lane_byte = dmem_in[15:8];
            4'b0100: lane_byte = dmem_in[23:16];
            4'b1000: lane_byte = dmem_in[31:24];
            default: lane_byte = dmem_in[7:0];
        endcase
    end

    // Upper pair only when both high lanes are on
    assign lane_half = (byte_en == 4'b1100) ? dmem_in[31:16] : dmem_in[15:0];

    always_comb begin
        case (load_type)
            LB:      ext_out = {{24{lane_byte[7]}}, lane_byte};
            LBU:     ext_out = {24'b0, lane_byte};
            LH:      ext_out = {{16{lane_half[15]}}, lane_half};
            LHU:     ext_out = {16'b0, lane_half};
            LW:      ext_out = dmem_in;
            default: ext_out = '0;
        endcase
    end

endmodule

/* mem_stage/fence_tracker.sv */
`timescale 1ns/10ps

module fence_tracker (
    input  logic CLK,
    input  logic nRST,
    input  logic fence_req,
    input  logic done_a,
    input  logic done_b,
    output logic fence_pulse,
    output logic stall
);
    logic armed;
    logic armed_next;
    logic a_done;
    logic a_done_next;
    logic b_done;
    logic b_done_next;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            armed  <= 1'b0;
            a_done <= 1'b1;
            b_done <= 1'b1;
        end else begin
            armed  <= armed_next;
            a_done <= a_done_next;
            b_done <= b_done_next;
        end
    end

    // Rising edge of the held request
    assign fence_pulse = fence_req && !armed;

    always_comb begin
        armed_next  = armed;
        a_done_next = a_done;
        b_done_next = b_done;
        if (fence_pulse) begin
            armed_next  = 1'b1;
            a_done_next = 1'b0;
            b_done_next = 1'b0;
        end
        if (done_a)
            a_done_next = 1'b1;
        if (done_b)
            b_done_next = 1'b1;
        // Stay armed until finished and the request has been released
        if (a_done_next && b_done_next && !fence_req)
            armed_next = 1'b0;
    end

    assign stall = armed && !(a_done && b_done);

endmodule

/* mem_stage/mem_stage.sv */
`timescale 1ns/10ps

module mem_stage
    import mem_stage_pkg::*;
(
    input  logic        CLK,
    input  logic        nRST,
    input  ex_mem_reg_t ex_mem_reg,
    input  logic        suppress_data,
    input  dbus_rsp_t   dbus_rsp,
    input  logic        iflush_done,
    input  logic        dflush_done,
    input  logic        itlb_done,
    input  logic        dtlb_done,
    output dbus_req_t   dbus_req,
    output logic        icache_flush,
    output logic        dcache_flush,
    output logic        itlb_fence,
    output logic        dtlb_fence,
    output logic        fence_stall,
    output logic        reg_write,
    output logic [4:0]  rd,
    output word_t       reg_wdata,
    output mem_exc_t    exc,
    output logic        halt
);
    word_t      dload_ext;
    logic       mal_addr;
    logic [1:0] byte_offset;
    logic [3:0] byte_en;
    logic       cache_pulse;
    logic       cache_stall;
    logic       tlb_pulse;
    logic       tlb_stall;

    assign byte_offset = ex_mem_reg.port_out[1:0];

    // Bus request, strobes dropped when the stage is suppressed
    assign dbus_req.ren     = ex_mem_reg.dren && !suppress_data;
    assign dbus_req.wen     = ex_mem_reg.dwen && !suppress_data;
    assign dbus_req.addr    = ex_mem_reg.port_out;
    assign dbus_req.byte_en = byte_en;

    // Lane n carries address byte n
    always_comb begin
        case (ex_mem_reg.load_type)
            LB, LBU: byte_en = 4'b0001 << byte_offset;
            LH, LHU: begin
                case (byte_offset)
                    2'b00:   byte_en = 4'b0011;
                    2'b10:   byte_en = 4'b1100;
                    default: byte_en = 4'b0000;
                endcase
            end
            LW:      byte_en = (byte_offset == 2'b00) ? 4'b1111 : 4'b0000;
            default: byte_en = 4'b0000;
        endcase
    end

    // Store data copied onto every lane
    always_comb begin
        case (ex_mem_reg.load_type)
            LB:      dbus_req.wdata = {4{ex_mem_reg.rs2_data[7:0]}};
            LH:      dbus_req.wdata = {2{ex_mem_reg.rs2_data[15:0]}};
            LW:      dbus_req.wdata = ex_mem_reg.rs2_data;
            default: dbus_req.wdata = '0;
        endcase
    end

    always_comb begin
        case (ex_mem_reg.load_type)
            LW:      mal_addr = (byte_offset != 2'b00);
            LH, LHU: mal_addr = byte_offset[0];
            default: mal_addr = 1'b0;
        endcase
    end

    assign exc.mal_l   = ex_mem_reg.dren && mal_addr;
    assign exc.mal_s   = ex_mem_reg.dwen && mal_addr;
    assign exc.fault_l = ex_mem_reg.dren && dbus_rsp.error;
    assign exc.fault_s = ex_mem_reg.dwen && dbus_rsp.error;

    dmem_extender dmem_ext (
        .dmem_in   (dbus_rsp.rdata),
        .load_type (ex_mem_reg.load_type),
        .byte_en   (byte_en),
        .ext_out   (dload_ext)
    );

    // Cache fence drives both flush engines
    fence_tracker cache_fence (
        .CLK         (CLK),
        .nRST        (nRST),
        .fence_req   (ex_mem_reg.ifence),
        .done_a      (iflush_done),
        .done_b      (dflush_done),
        .fence_pulse (cache_pulse),
        .stall       (cache_stall)
    );

    fence_tracker tlb_fence (
        .CLK         (CLK),
        .nRST        (nRST),
        .fence_req   (ex_mem_reg.sfence),
        .done_a      (itlb_done),
        .done_b      (dtlb_done),
        .fence_pulse (tlb_pulse),
        .stall       (tlb_stall)
    );

    assign icache_flush = cache_pulse;
    assign dcache_flush = cache_pulse;
    assign itlb_fence   = tlb_pulse;
    assign dtlb_fence   = tlb_pulse;
    assign fence_stall  = cache_stall || tlb_stall;

    // Writeback
    assign reg_write = ex_mem_reg.reg_write && !suppress_data;
    assign rd        = ex_mem_reg.rd_m;
    assign halt      = ex_mem_reg.halt;

    always_comb begin
        case (ex_mem_reg.w_sel)
            W_SEL_FROM_DLOAD: reg_wdata = dload_ext;
            W_SEL_FROM_PC:    reg_wdata = ex_mem_reg.pc4;
            W_SEL_FROM_IMM_U: reg_wdata = ex_mem_reg.imm_U;
            W_SEL_FROM_ALU:   reg_wdata = ex_mem_reg.port_out;
            default:          reg_wdata = '0;
        endcase
    end

endmodule

/* hdl/data_ram.sv */
`timescale 1ns/10ps
`include "mem_stage_params.svh"

module data_ram
    import mem_stage_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  dbus_req_t req,
    output dbus_rsp_t rsp
);
    localparam int IDX_W = $clog2(`RAM_WORDS);

    word_t            mem [`RAM_WORDS];
    logic             phase;
    logic             live;
    logic             complete;
    logic             in_range;
    logic [IDX_W-1:0] idx;

    assign live     = req.ren || req.wen;
    assign complete = live && phase;
    assign in_range = (req.addr < `RAM_WORDS * 4);
    assign idx      = req.addr[2 +: IDX_W];

    // One wait state, second cycle completes
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            phase <= 1'b0;
        else
            phase <= live && !phase;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `RAM_WORDS; i++)
                mem[i] <= '0;
        end else if (complete && req.wen && in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (req.byte_en[b])
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
    end

    assign rsp.busy  = live && !phase;
    assign rsp.error = complete && !in_range;
    assign rsp.rdata = (complete && req.ren && in_range) ? mem[idx] : '0;

endmodule

/* hdl/maint_engine.sv */
`timescale 1ns/10ps
`include "mem_stage_params.svh"

module maint_engine (
    input  logic CLK,
    input  logic nRST,
    input  logic icache_flush,
    input  logic dcache_flush,
    input  logic itlb_fence,
    input  logic dtlb_fence,
    output logic iflush_done,
    output logic dflush_done,
    output logic itlb_done,
    output logic dtlb_done
);
    localparam int CNT_W = 4;

    // Busy times, index order icache, dcache, itlb, dtlb
    localparam logic [3:0][CNT_W-1:0] LAT = {
        CNT_W'(`DTLB_CYCLES), CNT_W'(`ITLB_CYCLES),
        CNT_W'(`DFLUSH_CYCLES), CNT_W'(`IFLUSH_CYCLES)
    };

    logic [3:0]            start;
    logic [3:0]            done;
    logic [3:0][CNT_W-1:0] cnt;

    assign start = {dtlb_fence, itlb_fence, dcache_flush, icache_flush};

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cnt <= '0;
        end else begin
            for (int e = 0; e < 4; e++) begin
                if (start[e])
                    cnt[e] <= LAT[e];
                else if (cnt[e] != '0)
                    cnt[e] <= cnt[e] - 1'b1;
            end
        end
    end

    // Last busy cycle is N cycles after the request
    always_comb begin
        for (int e = 0; e < 4; e++)
            done[e] = (cnt[e] == CNT_W'(1));
    end

    assign {dtlb_done, itlb_done, dflush_done, iflush_done} = done;

endmodule

/* hdl/mem_subsys_top.sv */
`timescale 1ns/10ps

module mem_subsys_top
    import mem_stage_pkg::*;
(
    input  logic        CLK,
    input  logic        nRST,
    input  ex_mem_reg_t ex_mem_reg,
    input  logic        suppress_data,
    output logic        reg_write,
    output logic [4:0]  rd,
    output word_t       reg_wdata,
    output mem_exc_t    exc,
    output logic        mem_busy,
    output logic        fence_stall,
    output logic        halt
);
    dbus_req_t dbus_req;
    dbus_rsp_t dbus_rsp;
    logic      icache_flush;
    logic      dcache_flush;
    logic      itlb_fence;
    logic      dtlb_fence;
    logic      iflush_done;
    logic      dflush_done;
    logic      itlb_done;
    logic      dtlb_done;

    mem_stage mem_stage_i (
        .CLK           (CLK),
        .nRST          (nRST),
        .ex_mem_reg    (ex_mem_reg),
        .suppress_data (suppress_data),
        .dbus_rsp      (dbus_rsp),
        .iflush_done   (iflush_done),
        .dflush_done   (dflush_done),
        .itlb_done     (itlb_done),
        .dtlb_done     (dtlb_done),
        .dbus_req      (dbus_req),
        .icache_flush  (icache_flush),
        .dcache_flush  (dcache_flush),
        .itlb_fence    (itlb_fence),
        .dtlb_fence    (dtlb_fence),
        .fence_stall   (fence_stall),
        .reg_write     (reg_write),
        .rd            (rd),
        .reg_wdata     (reg_wdata),
        .exc           (exc),
        .halt          (halt)
    );

    data_ram data_ram_i (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (dbus_req),
        .rsp  (dbus_rsp)
    );

    maint_engine maint_engine_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .icache_flush (icache_flush),
        .dcache_flush (dcache_flush),
        .itlb_fence   (itlb_fence),
        .dtlb_fence   (dtlb_fence),
        .iflush_done  (iflush_done),
        .dflush_done  (dflush_done),
        .itlb_done    (itlb_done),
        .dtlb_done    (dtlb_done)
    );

    assign mem_busy = dbus_rsp.busy;

endmodule

/* test/mem_subsys_assert.sv */
`timescale 1ns/10ps

module mem_subsys_assert
    import mem_stage_pkg::*;
(
    input logic      CLK,
    input logic      nRST,
    input dbus_req_t dbus_req,
    input logic      mal_addr,
    input logic      cache_pulse,
    input logic      cache_stall,
    input logic      tlb_pulse,
    input logic      tlb_stall
);
    logic live;
    int   fail_count = 0;

    assign live = dbus_req.ren || dbus_req.wen;

    // Fence pulses are single cycle
    cache_pulse_width: assert property (@(posedge CLK) disable iff (!nRST)
        cache_pulse |=> !cache_pulse)
        else begin
            fail_count++;
            $error("cache fence pulse lasted more than one cycle");
        end

    tlb_pulse_width: assert property (@(posedge CLK) disable iff (!nRST)
        tlb_pulse |=> !tlb_pulse)
        else begin
            fail_count++;
            $error("TLB fence pulse lasted more than one cycle");
        end

    // Stall starts in the cycle after the pulse
    cache_pulse_stall: assert property (@(posedge CLK) disable iff (!nRST)
        cache_pulse |=> cache_stall)
        else begin
            fail_count++;
            $error("cache fence pulse not followed by a stall");
        end

    tlb_pulse_stall: assert property (@(posedge CLK) disable iff (!nRST)
        tlb_pulse |=> tlb_stall)
        else begin
            fail_count++;
            $error("TLB fence pulse not followed by a stall");
        end

    strobes_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
        !(dbus_req.ren && dbus_req.wen))
        else begin
            fail_count++;
            $error("read and write strobes high together");
        end

    // Aligned live request needs at least one lane
    lanes_enabled: assert property (@(posedge CLK) disable iff (!nRST)
        (live && !mal_addr) |-> (dbus_req.byte_en != 4'b0000))
        else begin
            fail_count++;
            $error("aligned bus request with no byte lane enabled");
        end

endmodule

/* test/mem_subsys_tb.sv */
`timescale 1ns/10ps
`include "mem_stage_params.svh"

module mem_subsys_tb
    import mem_stage_pkg::*;
();
    localparam int TIMEOUT = 20;

    logic        CLK;
    logic        nRST;
    ex_mem_reg_t ex_mem_reg;
    logic        suppress_data;
    logic        reg_write;
    logic [4:0]  rd;
    word_t       reg_wdata;
    mem_exc_t    exc;
    logic        mem_busy;
    logic        fence_stall;
    logic        halt;
    ex_mem_reg_t idle_rec;
    logic [7:0]  model [1024];
    int          seed = 9;
    int          bus_wait = 0;

    bind mem_stage mem_subsys_assert stage_checks (
        .CLK         (CLK),
        .nRST        (nRST),
        .dbus_req    (dbus_req),
        .mal_addr    (mal_addr),
        .cache_pulse (cache_pulse),
        .cache_stall (cache_stall),
        .tlb_pulse   (tlb_pulse),
        .tlb_stall   (tlb_stall)
    );

    mem_subsys_top dut_i (
        .CLK           (CLK),
        .nRST          (nRST),
        .ex_mem_reg    (ex_mem_reg),
        .suppress_data (suppress_data),
        .reg_write     (reg_write),
        .rd            (rd),
        .reg_wdata     (reg_wdata),
        .exc           (exc),
        .mem_busy      (mem_busy),
        .fence_stall   (fence_stall),
        .halt          (halt)
    );

    always #50 CLK = ~CLK;

    always @(negedge CLK) begin
        if (dut_i.mem_stage_i.stage_checks.fail_count != 0) begin
            $display("A bound assertion on the memory stage failed");
            $display("Finished with errors");
            $fatal(1, "Simulation stopped on an assertion failure");
        end
    end

    function automatic ex_mem_reg_t make_record(logic dren, logic dwen, load_type_t kind,
            w_sel_t sel, word_t addr, word_t data);
        ex_mem_reg_t r;
        r = '0;
        r.dren = dren;
        r.dwen = dwen;
        r.load_type = kind;
        r.w_sel = sel;
        r.port_out = addr;
        r.rs2_data = data;
        r.rd_m = 5'($random(seed));
        r.reg_write = 1'($random(seed));
        return r;
    endfunction

    // Expected load value, little-endian lanes
    function automatic word_t model_read(word_t addr, load_type_t kind);
        int         a;
        logic [7:0] b0;
        logic [7:0] b1;
        a = addr[9:0];
        b0 = model[a];
        b1 = model[a + 1];
        case (kind)
            LB:      return {{24{b0[7]}}, b0};
            LBU:     return {24'b0, b0};
            LH:      return {{16{b1[7]}}, b1, b0};
            LHU:     return {16'b0, b1, b0};
            default: return {model[a + 3], model[a + 2], b1, b0};
        endcase
    endfunction

    function automatic void model_write(word_t addr, load_type_t kind, word_t data);
        int a;
        a = addr[9:0];
        model[a] = data[7:0];
        if (kind != LB)
            model[a + 1] = data[15:8];
        if (kind == LW) begin
            model[a + 2] = data[23:16];
            model[a + 3] = data[31:24];
        end
    endfunction

    function automatic word_t aligned_addr(load_type_t kind, int range);
        word_t addr;
        addr = $unsigned($random(seed)) % range;
        if (kind == LH || kind == LHU)
            addr[0] = 1'b0;
        if (kind == LW)
            addr[1:0] = 2'b00;
        return addr;
    endfunction

    function automatic int max_of(int a, int b);
        return (a > b) ? a : b;
    endfunction

    task automatic check_value(string name, word_t expected, word_t actual);
        assert (expected === actual) else begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "Check %s failed", name);
        end
    endtask

    task automatic report_timeout(string what);
        $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped on a timeout");
    endtask

    // Ends at the falling edge of the completing cycle
    task automatic wait_bus_done();
        int n;
        n = 0;
        @(negedge CLK);
        while (mem_busy && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        bus_wait = n;
        if (mem_busy)
            report_timeout("memory bus completion");
    endtask

    task automatic wait_stall(logic level, output int cycles);
        cycles = 0;
        @(negedge CLK);
        while (fence_stall !== level && cycles < TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (fence_stall !== level)
            report_timeout(level ? "fence stall rise" : "fence stall fall");
    endtask

    task automatic start_access(ex_mem_reg_t rec, logic supp);
        @(posedge CLK);
        #5;
        ex_mem_reg = rec;
        suppress_data = supp;
        wait_bus_done();
    endtask

    task automatic end_access();
        @(posedge CLK);
        #5;
        ex_mem_reg = idle_rec;
        suppress_data = 1'b0;
    endtask

    task automatic verify_word(word_t addr, string name);
        ex_mem_reg_t rec;
        rec = make_record(1'b1, 1'b0, LW, W_SEL_FROM_DLOAD, {22'b0, addr[9:2], 2'b00}, '0);
        start_access(rec, 1'b0);
        check_value(name, model_read(rec.port_out, LW), reg_wdata);
        end_access();
    endtask

    task automatic load_store_test(int count);
        ex_mem_reg_t rec;
        load_type_t  kind;
        logic        is_store;
        for (int i = 0; i < count; i++) begin
            is_store = 1'($random(seed));
            kind = load_type_t'($unsigned($random(seed)) % (is_store ? 3 : 5));
            // Small window so loads hit earlier stores
            rec = make_record(!is_store, is_store, kind, W_SEL_FROM_DLOAD,
                aligned_addr(kind, 64), $random(seed));
            start_access(rec, 1'b0);
            // One wait state before completion
            check_value("ls_wait_states", 1, bus_wait);
            check_value("ls_reg_write", rec.reg_write, reg_write);
            check_value("ls_rd", rec.rd_m, rd);
            check_value("ls_exc", '0, exc);
            if (is_store)
                model_write(rec.port_out, kind, rec.rs2_data);
            else
                check_value("ls_load_data", model_read(rec.port_out, kind), reg_wdata);
            end_access();
        end
    endtask

    task automatic misalign_test(int count);
        ex_mem_reg_t rec;
        load_type_t  kind;
        logic        is_store;
        word_t       addr;
        for (int i = 0; i < count; i++) begin
            is_store = 1'($random(seed));
            kind = $random(seed) % 2 ? LH : LW;
            addr = $unsigned($random(seed)) % 64;
            if (kind == LH || addr[1:0] == 2'b00)
                addr[0] = 1'b1;
            rec = make_record(!is_store, is_store, kind, W_SEL_FROM_DLOAD, addr, $random(seed));
            start_access(rec, 1'b1);
            check_value("mal_l", !is_store, exc.mal_l);
            check_value("mal_s", is_store, exc.mal_s);
            end_access();
            verify_word(addr, "mal_unchanged");
        end
    endtask

    task automatic fault_test(int count);
        ex_mem_reg_t rec;
        logic        is_store;
        word_t       addr;
        for (int i = 0; i < count; i++) begin
            is_store = 1'($random(seed));
            addr = 1024 + aligned_addr(LW, 8192);
            rec = make_record(!is_store, is_store, LW, W_SEL_FROM_DLOAD, addr, $random(seed));
            start_access(rec, 1'b0);
            check_value("fault_l", !is_store, exc.fault_l);
            check_value("fault_s", is_store, exc.fault_s);
            end_access();
            // Aliased in-range word must be untouched
            verify_word(addr, "fault_unchanged");
        end
    endtask

    task automatic writeback_test(int count);
        ex_mem_reg_t rec;
        w_sel_t      sel;
        word_t       expected;
        for (int i = 0; i < count; i++) begin
            sel = w_sel_t'(1 + $unsigned($random(seed)) % 3);
            rec = make_record(1'b0, 1'b0, NONE, sel, $random(seed), '0);
            rec.pc4 = $random(seed);
            rec.imm_U = $random(seed);
            rec.halt = 1'($random(seed));
            case (sel)
                W_SEL_FROM_PC:    expected = rec.pc4;
                W_SEL_FROM_IMM_U: expected = rec.imm_U;
                default:          expected = rec.port_out;
            endcase
            start_access(rec, 1'b0);
            check_value("wb_data", expected, reg_wdata);
            check_value("wb_halt", rec.halt, halt);
            check_value("wb_reg_write", rec.reg_write, reg_write);
            end_access();
        end
    endtask

    task automatic fence_test(logic use_sfence, int expected_len, string name);
        ex_mem_reg_t rec;
        int          n;
        rec = idle_rec;
        rec.ifence = !use_sfence;
        rec.sfence = use_sfence;
        // Second round needs the request dropped in between
        for (int rep = 0; rep < 2; rep++) begin
            @(posedge CLK);
            #5;
            ex_mem_reg = rec;
            wait_stall(1'b1, n);
            check_value({name, "_rise"}, 1, n);
            wait_stall(1'b0, n);
            check_value({name, "_len"}, expected_len, n + 1);
            repeat (3) begin
                @(negedge CLK);
                check_value({name, "_once"}, 0, fence_stall);
            end
            end_access();
        end
    endtask

    task automatic suppress_test(int count);
        ex_mem_reg_t rec;
        load_type_t  kind;
        for (int i = 0; i < count; i++) begin
            kind = load_type_t'($unsigned($random(seed)) % 3);
            rec = make_record(1'b0, 1'b1, kind, W_SEL_FROM_DLOAD,
                aligned_addr(kind, 64), $random(seed));
            rec.reg_write = 1'b1;
            start_access(rec, 1'b1);
            check_value("sup_reg_write", 0, reg_write);
            end_access();
            verify_word(rec.port_out, "sup_unchanged");
        end
    endtask

    initial begin
        CLK = 1'b0;
        nRST = 1'b0;
        idle_rec = '0;
        idle_rec.load_type = NONE;
        idle_rec.w_sel = W_SEL_FROM_ALU;
        ex_mem_reg = idle_rec;
        suppress_data = 1'b0;
        for (int i = 0; i < 1024; i++)
            model[i] = 8'h00;
        repeat (3) @(posedge CLK);
        #5;
        nRST = 1'b1;
        @(negedge CLK);
        check_value("reset_stall", 0, fence_stall);
        check_value("reset_busy", 0, mem_busy);
        check_value("reset_reg_write", 0, reg_write);
        check_value("reset_exc", '0, exc);
        load_store_test(60);
        misalign_test(10);
        fault_test(8);
        writeback_test(10);
        fence_test(1'b0, max_of(`IFLUSH_CYCLES, `DFLUSH_CYCLES), "ifence");
        fence_test(1'b1, max_of(`ITLB_CYCLES, `DTLB_CYCLES), "sfence");
        suppress_test(8);
        if (dut_i.mem_stage_i.stage_checks.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* mem_subsys.f */
+incdir+common
common/mem_stage_pkg.sv
mem_stage/dmem_extender.sv
mem_stage/fence_tracker.sv
mem_stage/mem_stage.sv
hdl/data_ram.sv
hdl/maint_engine.sv
hdl/mem_subsys_top.sv
test/mem_subsys_assert.sv
test/mem_subsys_tb.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - include_dirs:
      - common
    files:
      - common/mem_stage_pkg.sv
      - mem_stage/dmem_extender.sv
      - mem_stage/fence_tracker.sv
      - mem_stage/mem_stage.sv
      - hdl/data_ram.sv
      - hdl/maint_engine.sv
      - hdl/mem_subsys_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/mem_subsys_assert.sv
      - test/mem_subsys_tb.sv
